// File: hebe_pkg.sv
`default_nettype none

package hebe_pkg;

  localparam int line_w        = 512;
  localparam int lanes         = 32;
  localparam int elem_w        = 16;
  localparam int conf_w        = 32;
  localparam int conf_per_line = 16;

  typedef enum logic [2:0] {
    op_pass,
    op_add,
    op_sub,
    op_mul,
    op_xor,
    op_max,
    op_min,
    op_clr
  } lane_op_e;

  typedef struct packed {
    logic                     kind;  // Zero for a lane word.
    logic [$clog2(lanes)-1:0] lane;
    lane_op_e                 op;
    logic [6:0]               rsvd;
    logic [elem_w-1:0]        imm;
  } lane_conf_s;

  typedef struct packed {
    logic              kind;  // One for a global word.
    logic [conf_w-6:0] rsvd;
    logic [3:0]        shift;
  } glob_conf_s;

  // Bit 31 selects which of the two views applies.
  typedef union packed {
    lane_conf_s lane;
    glob_conf_s glob;
  } conf_word_u;

  typedef struct packed {
    logic       valid;
    conf_word_u word;
  } conf_bus_s;

  typedef struct packed {
    logic              valid;
    logic [line_w-1:0] data;
  } line_bus_s;

  typedef struct packed {
    lane_op_e          op;
    logic [elem_w-1:0] imm;
  } lane_cfg_s;

endpackage

`default_nettype wire

// File: hebe_in32.sv
`timescale 1ns/1ps
`default_nettype none

module hebe_in32 (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        start,
  input  logic [31:0]                 num_data,
  input  logic [31:0]                 num_conf,
  input  logic                        available_read,
  input  logic                        out_rdy,
  input  logic [hebe_pkg::line_w-1:0] rd_data,
  output logic                        req_rd_data,
  output hebe_pkg::conf_bus_s         conf,
  output hebe_pkg::line_bus_s         line,
  output logic                        fetch_done
);
  import hebe_pkg::*;

  enum logic [1:0] {st_wait, st_read, st_done} state;

  logic [$clog2(conf_per_line)-1:0] widx;
  logic [31:0]                      cnt_conf;
  logic [31:0]                      cnt_data;
  logic                             rd_valid;
  logic [line_w-1:0]                line_q;
  logic [line_w-1:0]                src;
  conf_word_u                       word;
  logic                             conf_left;
  logic                             last_word;
  logic                             issue;
  logic                             conf_valid_q;
  conf_word_u                       conf_word_q;

  // The fresh line is on rd_data only in the cycle after the request.
  assign src       = rd_valid ? rd_data : line_q;
  assign word      = src[widx*conf_w +: conf_w];
  assign conf_left = cnt_conf < num_conf;

  // Leftover words in a line are dropped after the last configuration word.
  assign last_word = (&widx) || (cnt_conf + 32'd1 >= num_conf);

  // A held data line goes out in the first cycle the output side has room.
  assign issue = start && (state == st_read) && !req_rd_data && !rd_valid && !conf_left &&
                 out_rdy;

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= st_wait;
      req_rd_data  <= 1'b0;
      rd_valid     <= 1'b0;
      cnt_conf     <= '0;
      cnt_data     <= '0;
      widx         <= '0;
      conf_valid_q <= 1'b0;
    end else begin
      req_rd_data  <= 1'b0;
      conf_valid_q <= 1'b0;
      rd_valid     <= req_rd_data;
      if (start) begin
        case (state)
          st_wait: begin
            if (cnt_data >= num_data) begin
              state <= st_done;
            end else if (available_read) begin
              req_rd_data <= 1'b1;
              state       <= st_read;
            end
          end
          st_read: begin
            if (conf_left && !req_rd_data) begin  // The requested line is not here yet.
              conf_valid_q <= 1'b1;
              cnt_conf     <= cnt_conf + 32'd1;
              widx         <= widx + 1'b1;
              if (last_word) begin
                widx  <= '0;
                state <= st_wait;  // Fetch the next line from the wait state.
              end
            end else if (issue) begin
              cnt_data <= cnt_data + lanes;  // One line carries 32 elements.
              state    <= st_wait;
            end
          end
          default: begin
            state <= st_done;
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_valid) begin
      line_q <= rd_data;
    end
    conf_word_q <= word;
  end

  assign conf       = '{valid: conf_valid_q, word: conf_word_q};
  assign line       = '{valid: issue, data: line_q};
  assign fetch_done = (state == st_done);

endmodule

`default_nettype wire

// File: hebe_conf.sv
`timescale 1ns/1ps
`default_nettype none

module hebe_conf (
  input  logic                                       clk,
  input  logic                                       rst,
  input  hebe_pkg::conf_bus_s                        conf,
  output hebe_pkg::lane_cfg_s [hebe_pkg::lanes-1:0]  lane_cfg,
  output logic [3:0]                                 shift
);
  import hebe_pkg::*;

  lane_conf_s lane_word;
  glob_conf_s glob_word;

  // Both views of the same word.
  assign lane_word = conf.word.lane;
  assign glob_word = conf.word.glob;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < lanes; i++) begin
        lane_cfg[i].op  <= op_pass;
        lane_cfg[i].imm <= '0;
      end
      shift <= '0;
    end else if (conf.valid) begin
      if (glob_word.kind) begin
        shift <= glob_word.shift;  // Applies to every lane.
      end else begin
        lane_cfg[lane_word.lane].op  <= lane_word.op;
        lane_cfg[lane_word.lane].imm <= lane_word.imm;
      end
    end
  end

endmodule

`default_nettype wire

// File: hebe_lanes.sv
`timescale 1ns/1ps
`default_nettype none

module hebe_lanes (
  input  logic                                      clk,
  input  logic                                      rst,
  input  hebe_pkg::line_bus_s                       line,
  input  hebe_pkg::lane_cfg_s [hebe_pkg::lanes-1:0] lane_cfg,
  input  logic [3:0]                                shift,
  output hebe_pkg::line_bus_s                       result
);
  import hebe_pkg::*;

  logic [line_w-1:0] res_d;
  logic [line_w-1:0] res_q;
  logic              valid_q;

  for (genvar k = 0; k < lanes; k++) begin : g_lane
    logic [elem_w-1:0] elem;
    logic [elem_w-1:0] imm;
    logic [elem_w-1:0] op_res;

    assign elem = line.data[k*elem_w +: elem_w];
    assign imm  = lane_cfg[k].imm;

    always_comb begin
      case (lane_cfg[k].op)
        op_pass: op_res = elem;
        op_add:  op_res = elem + imm;
        op_sub:  op_res = elem - imm;
        op_mul:  op_res = elem * imm;  // Keeps the low half of the product.
        op_xor:  op_res = elem ^ imm;
        op_max:  op_res = (elem > imm) ? elem : imm;
        op_min:  op_res = (elem < imm) ? elem : imm;
        default: op_res = '0;
      endcase
    end

    assign res_d[k*elem_w +: elem_w] = op_res >> shift;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= line.valid;
    end
  end

  always_ff @(posedge clk) begin
    res_q <= res_d;
  end

  assign result = '{valid: valid_q, data: res_q};

endmodule

`default_nettype wire

// File: hebe_out32.sv
`timescale 1ns/1ps
`default_nettype none

module hebe_out32 (
  input  logic                        clk,
  input  logic                        rst,
  input  hebe_pkg::line_bus_s         result,
  input  logic                        fetch_done,
  output logic                        out_wr,
  output logic [hebe_pkg::line_w-1:0] out_data,
  output logic                        done
);
  import hebe_pkg::*;

  logic              fd_q;
  logic              done_q;
  logic [line_w-1:0] data_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_wr <= 1'b0;
      fd_q   <= 1'b0;
      done_q <= 1'b0;
    end else begin
      out_wr <= result.valid;
      fd_q   <= fetch_done;
      done_q <= done_q | fd_q;  // Covers the two lines still in the pipeline.
    end
  end

  always_ff @(posedge clk) begin
    if (result.valid) begin
      data_q <= result.data;
    end
  end

  assign out_data = data_q;
  assign done     = done_q;

endmodule

`default_nettype wire

// File: hebe_top.sv
`timescale 1ns/1ps
`default_nettype none

module hebe_top (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        start,
  input  logic [31:0]                 num_data,
  input  logic [31:0]                 num_conf,
  input  logic                        available_read,
  input  logic [hebe_pkg::line_w-1:0] rd_data,
  input  logic                        out_rdy,
  output logic                        req_rd_data,
  output logic                        out_wr,
  output logic [hebe_pkg::line_w-1:0] out_data,
  output logic                        done
);
  import hebe_pkg::*;

  conf_bus_s              conf;
  line_bus_s              line;
  line_bus_s              result;
  lane_cfg_s [lanes-1:0]  lane_cfg;
  logic [3:0]             shift;
  logic                   fetch_done;

  hebe_in32 reader0 (
    .clk            (clk),
    .rst            (rst),
    .start          (start),
    .num_data       (num_data),
    .num_conf       (num_conf),
    .available_read (available_read),
    .out_rdy        (out_rdy),
    .rd_data        (rd_data),
    .req_rd_data    (req_rd_data),
    .conf           (conf),
    .line           (line),
    .fetch_done     (fetch_done)
  );

  hebe_conf conf0 (
    .clk      (clk),
    .rst      (rst),
    .conf     (conf),
    .lane_cfg (lane_cfg),
    .shift    (shift)
  );

  hebe_lanes lanes0 (
    .clk      (clk),
    .rst      (rst),
    .line     (line),
    .lane_cfg (lane_cfg),
    .shift    (shift),
    .result   (result)
  );

  hebe_out32 out0 (
    .clk        (clk),
    .rst        (rst),
    .result     (result),
    .fetch_done (fetch_done),
    .out_wr     (out_wr),
    .out_data   (out_data),
    .done       (done)
  );

endmodule

`default_nettype wire

// File: hebe_checker.sv
`timescale 1ns/1ps
`default_nettype none

module hebe_checker (
  input logic clk,
  input logic rst,
  input logic available_read,
  input logic req_rd_data,
  input logic out_rdy,
  input logic out_wr,
  input logic done,
  input logic line_valid
);
  int fails = 0;

  read_a: assert property (@(posedge clk) disable iff (rst) req_rd_data |-> available_read)
    else begin
      $error("Line requested while the read FIFO was empty");
      fails++;
    end

  reset_a: assert property (@(posedge clk) $fell(rst) |-> !req_rd_data && !out_wr && !done)
    else begin
      $error("Outputs not idle in the first cycle after reset");
      fails++;
    end

  done_a: assert property (@(posedge clk) disable iff (rst) $past(done) |-> done)
    else begin
      $error("done fell without a reset");
      fails++;
    end

  // Each data strobe comes out as a write two cycles later.
  latency_a: assert property (@(posedge clk) disable iff (rst) out_wr == $past(line_valid, 2))
    else begin
      $error("Write does not follow a data strobe by two cycles");
      fails++;
    end

  backpressure_a: assert property (@(posedge clk) disable iff (rst)
    $past(!out_rdy, 2) |-> !out_wr)
    else begin
      $error("Line written after the output FIFO ran short of room");
      fails++;
    end

endmodule

bind hebe_top hebe_checker chk0 (
  .clk            (clk),
  .rst            (rst),
  .available_read (available_read),
  .req_rd_data    (req_rd_data),
  .out_rdy        (out_rdy),
  .out_wr         (out_wr),
  .done           (done),
  .line_valid     (line.valid)
);

`default_nettype wire

// File: hebe_tb.sv
`timescale 1ns/1ps
`default_nettype none

module hebe_tb;
  import hebe_pkg::*;

  logic              clk;
  logic              rst;
  logic              start;
  logic [31:0]       num_data;
  logic [31:0]       num_conf;
  logic              available_read;
  logic [line_w-1:0] rd_data;
  logic              out_rdy;
  logic              req_rd_data;
  logic              out_wr;
  logic [line_w-1:0] out_data;
  logic              done;

  logic [line_w-1:0] rd_q [$];
  logic [line_w-1:0] exp_q [$];
  logic [conf_w-1:0] conf_q [$];
  lane_op_e          ref_op [lanes];
  logic [elem_w-1:0] ref_imm [lanes];
  logic [3:0]        ref_shift;
  integer            seed = 32'ha216_fc45;
  int                out_cnt = 0;
  int                writes = 0;
  int                cycles = 0;
  int                limit = 0;
  int                value_errors = 0;
  int                proto_errors = 0;

  hebe_top dut0 (
    .clk            (clk),
    .rst            (rst),
    .start          (start),
    .num_data       (num_data),
    .num_conf       (num_conf),
    .available_read (available_read),
    .rd_data        (rd_data),
    .out_rdy        (out_rdy),
    .req_rd_data    (req_rd_data),
    .out_wr         (out_wr),
    .out_data       (out_data),
    .done           (done)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [conf_w-1:0] lane_word(int lane, lane_op_e op, logic [15:0] imm);
    conf_word_u w;
    w           = '0;
    w.lane.lane = lane[4:0];
    w.lane.op   = op;
    w.lane.imm  = imm;
    return w;
  endfunction

  function automatic logic [conf_w-1:0] shift_word(logic [3:0] sh);
    conf_word_u w;
    w            = '0;
    w.glob.kind  = 1'b1;
    w.glob.shift = sh;
    return w;
  endfunction

  function automatic void apply_conf(logic [conf_w-1:0] raw);
    conf_word_u w;
    w = raw;
    if (w.glob.kind) begin
      ref_shift = w.glob.shift;
    end else begin
      ref_op[w.lane.lane]  = w.lane.op;
      ref_imm[w.lane.lane] = w.lane.imm;
    end
  endfunction

  function automatic logic [elem_w-1:0] elem_result(lane_op_e op, logic [15:0] e,
                                                    logic [15:0] imm);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    a = {16'h0, e};
    b = {16'h0, imm};
    case (op)
      op_pass: r = a;
      op_add:  r = a + b;
      op_sub:  r = a + 32'h1_0000 - b;
      op_mul:  r = a * b;
      op_xor:  r = a ^ b;
      op_max:  r = (a >= b) ? a : b;
      op_min:  r = (a <= b) ? a : b;
      default: r = '0;
    endcase
    r = (r & 32'hffff) >> ref_shift;  // Results wrap at 16 bits before the shift.
    return r[elem_w-1:0];
  endfunction

  function automatic logic [line_w-1:0] expect_line(logic [line_w-1:0] data);
    logic [line_w-1:0] res;
    for (int k = 0; k < lanes; k++) begin
      res[k*elem_w +: elem_w] = elem_result(ref_op[k], data[k*elem_w +: elem_w], ref_imm[k]);
    end
    return res;
  endfunction

  function automatic int lines_for(int nconf, int ndata);
    return (ndata == 0) ? 0 : (nconf + 15) / 16 + (ndata + 31) / 32;
  endfunction

  task automatic run_case(input int nconf, input int ndata);
    logic [line_w-1:0] line;
    logic [31:0]       rnd;
    int                nlines;
    @(posedge clk);
    rst      <= 1'b1;
    start    <= 1'b0;
    num_conf <= nconf;
    num_data <= ndata;
    @(posedge clk);
    writes = 0;
    nlines = (ndata + 31) / 32;
    for (int k = 0; k < lanes; k++) begin
      ref_op[k]  = op_pass;
      ref_imm[k] = '0;
    end
    ref_shift = '0;
    for (int i = 0; i < nconf; i++) begin
      apply_conf(conf_q[i]);
    end
    repeat (2) @(posedge clk);
    rst   <= 1'b0;
    start <= 1'b1;
    repeat (4) @(posedge clk);  // The reader first waits on an empty read FIFO.
    if (ndata > 0) begin
      for (int l = 0; l < (nconf + 15) / 16; l++) begin
        for (int j = 0; j < conf_per_line; j++) begin
          rnd = $random(seed);
          line[j*conf_w +: conf_w] = (l * 16 + j < nconf) ? conf_q[l * 16 + j] : rnd;
        end
        rd_q.push_back(line);
      end
    end
    for (int l = 0; l < nlines; l++) begin
      for (int k = 0; k < lanes; k++) begin
        rnd = $random(seed);
        line[k*elem_w +: elem_w] = rnd[elem_w-1:0];
      end
      rd_q.push_back(line);
      exp_q.push_back(expect_line(line));
    end
    while (!done) begin
      @(posedge clk);
    end
    assert (exp_q.size() == 0) else begin
      $display("done rose with %0d result lines still unwritten", exp_q.size());
      proto_errors++;
    end
    repeat (4) @(posedge clk);
    assert (writes == nlines) else begin
      $display("Fail writes expected %h actual %h", nlines, writes);
      value_errors++;
    end
    assert (rd_q.size() == 0) else begin
      $display("Read FIFO still holds %0d lines after the run", rd_q.size());
      proto_errors++;
    end
  endtask

  // Read FIFO with one cycle of read latency.
  always @(posedge clk) begin
    if (!rst && req_rd_data && rd_q.size() > 0) begin
      rd_data <= rd_q.pop_front();
    end
    available_read <= (rd_q.size() > 0);
  end

  // Output FIFO with four entries, drained at random.
  always @(posedge clk) begin : out_fifo
    int          next_cnt;
    logic [31:0] rnd;
    next_cnt = out_cnt;
    if (rst) begin
      next_cnt = 0;
    end else begin
      if (out_wr) begin
        next_cnt = next_cnt + 1;
      end
      if (out_cnt > 0) begin
        rnd = $random(seed);
        if (rnd[1:0] == 2'b00) begin
          next_cnt = next_cnt - 1;
        end
      end
      assert (next_cnt <= 4) else begin
        $display("Output FIFO overflowed with %0d entries", next_cnt);
        proto_errors++;
      end
    end
    out_cnt <= next_cnt;
    out_rdy <= (4 - next_cnt >= 3);
  end

  always @(posedge clk) begin : write_check
    logic [line_w-1:0] expected;
    if (!rst && out_wr) begin
      writes++;
      assert (exp_q.size() > 0) else begin
        $display("A line was written with no result line expected");
        proto_errors++;
      end
      if (exp_q.size() > 0) begin
        expected = exp_q.pop_front();
        assert (out_data == expected) else begin
          $display("Fail out_data expected %h actual %h", expected, out_data);
          value_errors++;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("Timeout after %0d cycles without finishing the tests", limit);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  initial begin : main
    logic [31:0] rnd;
    rst            = 1'b1;
    start          = 1'b0;
    num_data       = '0;
    num_conf       = '0;
    available_read = 1'b0;
    rd_data        = '0;
    out_rdy        = 1'b1;
    limit          = 40 * (lines_for(20, 200) + lines_for(5, 96)) + 200;
    for (int i = 0; i < 20; i++) begin
      rnd = $random(seed);
      conf_q.push_back(lane_word((i * 5) % lanes, lane_op_e'(i[2:0]), rnd[15:0]));
    end
    run_case(20, 200);  // Sixteen words in the first line, four in the second.
    conf_q.delete();
    conf_q.push_back(lane_word(3, op_add, 16'h1234));
    conf_q.push_back(lane_word(10, op_max, 16'h8000));
    conf_q.push_back(lane_word(31, op_sub, 16'h0101));
    conf_q.push_back(lane_word(3, op_mul, 16'h0007));
    conf_q.push_back(shift_word(4'd3));
    run_case(5, 96);
    conf_q.delete();
    conf_q.push_back(shift_word(4'd1));
    run_case(1, 0);
    $display("Errors: %0d value, %0d protocol, %0d assertion",
             value_errors, proto_errors, dut0.chk0.fails);
    if (value_errors + proto_errors + dut0.chk0.fails == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
hebe_pkg.sv
hebe_in32.sv
hebe_conf.sv
hebe_lanes.sv
hebe_out32.sv
hebe_top.sv
hebe_checker.sv
hebe_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module hebe_tb -f vlog.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vhebe_tb +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "ALL CHECKS PASSED" sim.log; then
  exit 0
fi
echo "Simulation did not pass"
exit 1
